/* design/fetch_macros.svh */
// Build-time constants of the fetch subsystem
// FETCH_DEPTH must be a power of two and at least 2
// MTVEC_W + IRQ_ID_W + 3 must equal 32 for the vectored trap target
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

//////////////////////////////////////////////////
// Prefetch buffer
//////////////////////////////////////////////////

// Entries in the prefetch FIFO, also the cap on bus requests in flight
`define FETCH_DEPTH 2

//////////////////////////////////////////////////
// Trap vectoring
//////////////////////////////////////////////////

// Interrupt id used as the vector table index
`define IRQ_ID_W 5
// Upper bits of mtvec, the vector table is 256-byte aligned
`define MTVEC_W 24

`endif

/* design/fetch_data_pkg.sv */
// Data widths of the fetch subsystem
// IRQ id and mtvec widths come from the macros header
// Addresses are byte addresses, fetch only ever uses word-aligned ones
`include "fetch_macros.svh"

package fetch_data_pkg;

  // Byte address on the fetch path
  typedef logic [31:0] addr_t;

  // One uncompressed instruction word
  typedef logic [31:0] instr_t;

  // Interrupt id for vectoring
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

  // Trap vector base, lower 8 bits of mtvec are implied zero
  typedef logic [`MTVEC_W-1:0] mtvec_t;

endpackage

/* design/fetch_ctrl_pkg.sv */
// Control encodings driven by the external controller
// Encodings are 3 bits wide, unused codes fall back to safe defaults

package fetch_ctrl_pkg;

  // Source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_mux_e;

  // Trap target, only looked at when the PC source is PC_EXCEPTION
  typedef enum logic [2:0] {
    // Synchronous exception, base of the vector table
    EXC_PC_EXCEPTION = 3'b000,
    // Vectored interrupt
    EXC_PC_IRQ       = 3'b001,
    // Debug halt entry
    EXC_PC_DBD       = 3'b010,
    // Exception while in debug mode
    EXC_PC_DBE       = 3'b011,
    // Non-maskable interrupt
    EXC_PC_NMI       = 3'b100
  } exc_pc_mux_e;

endpackage

/* design/fetch_bus_if.sv */
// Fetch request/response link between prefetch buffer and bus master
// One response per accepted request, in order, as a one-cycle pulse
// req_addr must hold while req_valid is high and req_ready is low
`timescale 1ns/10ps

interface fetch_bus_if;
  import fetch_data_pkg::*;

  // Request channel
  logic   req_valid;
  logic   req_ready;
  addr_t  req_addr;

  // Response channel, no back-pressure
  logic   rsp_valid;
  instr_t rsp_rdata;
  logic   rsp_err;

  // Prefetch buffer side
  modport requester (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  rsp_valid,
    input  rsp_rdata,
    input  rsp_err
  );

  // Bus master side
  modport responder (
    input  req_valid,
    input  req_addr,
    output req_ready,
    output rsp_valid,
    output rsp_rdata,
    output rsp_err
  );

endinterface

/* design/fetch_pc_select.sv */
// Next fetch address and trap target selection, purely combinational
// Output address is always word aligned
// Vectored IRQ target assumes mtvec base plus id fills exactly 32 bits
`timescale 1ns/10ps

module fetch_pc_select (
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_data_pkg::irq_id_t     irq_id_i,
  input  fetch_data_pkg::mtvec_t      mtvec_i,
  input  fetch_data_pkg::addr_t       boot_addr_i,
  input  fetch_data_pkg::addr_t       jump_target_i,
  input  fetch_data_pkg::addr_t       branch_target_i,
  input  fetch_data_pkg::addr_t       mepc_i,
  input  fetch_data_pkg::addr_t       dpc_i,
  input  fetch_data_pkg::addr_t       dm_halt_addr_i,
  input  fetch_data_pkg::addr_t       dm_exception_addr_i,
  input  fetch_data_pkg::addr_t       nmi_addr_i,
  input  fetch_data_pkg::addr_t       fencei_pc_i,
  input  logic                        pc_set_i,
  output fetch_data_pkg::addr_t       branch_addr_o,
  output logic                        csr_mtvec_init_o
);
  import fetch_ctrl_pkg::*;
  import fetch_data_pkg::*;

  addr_t exc_pc;
  addr_t addr_n;

  // Trap target
  always_comb
  begin
    unique case (exc_pc_mux_i)
      // All synchronous exceptions share the table base
      EXC_PC_EXCEPTION: exc_pc = {mtvec_i, 8'h00};
      // One word per interrupt id
      EXC_PC_IRQ:       exc_pc = {mtvec_i, 1'b0, irq_id_i, 2'b00};
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[31:2], 2'b00};
      EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[31:2], 2'b00};
      EXC_PC_NMI:       exc_pc = {nmi_addr_i[31:2], 2'b00};
      default:          exc_pc = {mtvec_i, 8'h00};
    endcase
  end

  // PC source
  always_comb
  begin
    unique case (pc_mux_i)
      PC_BOOT:      addr_n = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:      addr_n = jump_target_i;
      PC_BRANCH:    addr_n = branch_target_i;
      PC_EXCEPTION: addr_n = exc_pc;
      PC_MRET:      addr_n = mepc_i;
      PC_DRET:      addr_n = dpc_i;
      // Refetch starts right after the FENCE.I itself
      PC_FENCEI:    addr_n = fencei_pc_i + 32'd4;
      default:      addr_n = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  // No compressed support, so force word alignment
  assign branch_addr_o = {addr_n[31:2], 2'b00};

  // CSR file loads its mtvec reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

/* design/prefetch_buffer.sv */
// Prefetch buffer, FIFO of fetched words with their PC and error flag
// Requests in flight, stale ones included, never exceed FETCH_DEPTH
// A redirect empties the FIFO at once, stale responses are counted out
`timescale 1ns/10ps
`include "fetch_macros.svh"

module prefetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_set_i,
  input  fetch_data_pkg::addr_t branch_addr_i,
  input  logic                  ready_i,
  output logic                  valid_o,
  output fetch_data_pkg::instr_t instr_o,
  output fetch_data_pkg::addr_t pc_o,
  output logic                  err_o,
  output logic                  busy_o,
  fetch_bus_if.requester        bus
);
  import fetch_data_pkg::*;

  localparam int unsigned PTR_W = $clog2(`FETCH_DEPTH);
  localparam int unsigned CNT_W = $clog2(`FETCH_DEPTH + 1);
  localparam logic [CNT_W:0] DEPTH_C = `FETCH_DEPTH;

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  // Set by the first redirect, nothing is fetched before it
  logic             active_q;
  // Address of the next request
  addr_t            fetch_addr_q;
  // PC of the next live response
  addr_t            rsp_pc_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;
  // Live requests awaiting a response
  logic [CNT_W-1:0] out_q;
  logic [CNT_W-1:0] out_d;
  // Responses still due for the old stream
  logic [CNT_W-1:0] disc_q;
  logic [CNT_W-1:0] disc_d;
  logic [CNT_W:0]   inflight;

  // FIFO storage
  instr_t           word_q [`FETCH_DEPTH];
  addr_t            pc_q   [`FETCH_DEPTH];
  logic             err_q  [`FETCH_DEPTH];

  logic             accept;
  logic             rsp_live;
  logic             rsp_stale;
  logic             push;
  logic             pop;

  //////////////////////////////////////////////////
  // Request and response handling
  //////////////////////////////////////////////////

  // Stale requests still occupy a slot until their response drains
  assign inflight = count_q + out_q + disc_q;

  // Hold off during a redirect, fetch_addr_q is about to change
  assign bus.req_valid = active_q && !pc_set_i && (inflight < DEPTH_C);
  assign bus.req_addr  = fetch_addr_q;
  assign accept        = bus.req_valid && bus.req_ready;

  // Oldest responses belong to the old stream
  assign rsp_stale = bus.rsp_valid && (disc_q != '0);
  assign rsp_live  = bus.rsp_valid && (disc_q == '0);
  assign push      = rsp_live && !pc_set_i;
  assign pop       = valid_o && ready_i;

  // Counter updates
  always_comb
  begin
    count_d = count_q;
    out_d   = out_q;
    disc_d  = disc_q;
    if (push && !pop)
      count_d = count_q + 1'b1;
    else if (!push && pop)
      count_d = count_q - 1'b1;
    if (accept && !rsp_live)
      out_d = out_q + 1'b1;
    else if (!accept && rsp_live)
      out_d = out_q - 1'b1;
    if (rsp_stale)
      disc_d = disc_q - 1'b1;
    // Redirect, everything still open becomes stale
    if (pc_set_i)
    begin
      count_d = '0;
      disc_d  = disc_d + out_d;
      out_d   = '0;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      rsp_pc_q     <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
      count_q      <= '0;
      out_q        <= '0;
      disc_q       <= '0;
    end
    else
    begin
      count_q <= count_d;
      out_q   <= out_d;
      disc_q  <= disc_d;
      if (pc_set_i)
      begin
        active_q     <= 1'b1;
        fetch_addr_q <= branch_addr_i;
        rsp_pc_q     <= branch_addr_i;
        rd_ptr_q     <= '0;
        wr_ptr_q     <= '0;
      end
      else
      begin
        if (accept)
          fetch_addr_q <= fetch_addr_q + 32'd4;
        if (push)
        begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
          rsp_pc_q <= rsp_pc_q + 32'd4;
        end
        // Pointers wrap naturally, depth is a power of two
        if (pop)
          rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // FIFO
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      word_q[wr_ptr_q] <= bus.rsp_rdata;
      pc_q[wr_ptr_q]   <= rsp_pc_q;
      err_q[wr_ptr_q]  <= bus.rsp_err;
    end
  end

  // Head of the FIFO
  assign valid_o = (count_q != '0);
  assign instr_o = word_q[rd_ptr_q];
  assign pc_o    = pc_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];

  assign busy_o  = (out_q != '0) || (disc_q != '0);

endmodule

/* design/wb_instr_master.sv */
// Wishbone classic read master for single-word instruction fetches
// Only one bus cycle is open at a time, no pipelined mode
// cyc and stb drop for at least one cycle between transfers
`timescale 1ns/10ps

module wb_instr_master (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fetch_data_pkg::instr_t wb_dat_i,
  input  logic                   wb_ack_i,
  input  logic                   wb_err_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output fetch_data_pkg::addr_t  wb_adr_o,
  fetch_bus_if.responder         bus
);
  import fetch_data_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e state_q;
  state_e state_d;
  // Address of the open bus cycle
  addr_t  adr_q;
  logic   bus_done;

  // New request only when no cycle is open
  assign bus.req_ready = (state_q == IDLE);

  // Slave terminates with ack or err
  assign bus_done = (state_q == WAIT) && (wb_ack_i || wb_err_i);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      IDLE:
        if (bus.req_valid)
          state_d = WAIT;
      WAIT:
        if (bus_done)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // Captured on acceptance, held for the whole cycle
  always_ff @(posedge clk)
  begin
    if (bus.req_valid && bus.req_ready)
      adr_q <= bus.req_addr;
  end

  assign wb_cyc_o = (state_q == WAIT);
  assign wb_stb_o = (state_q == WAIT);
  assign wb_adr_o = adr_q;

  // Response is passed straight through in the terminating cycle
  assign bus.rsp_valid = bus_done;
  assign bus.rsp_rdata = wb_dat_i;
  assign bus.rsp_err   = wb_err_i;

endmodule

/* design/fetch_stage.sv */
// Instruction fetch stage, top level
// Word-aligned fetch only, no compressed instructions, no MPU/PMA
// Nothing is fetched until the first pc_set_i from the controller
// Controller must kill IF when it redirects while decode accepts
`timescale 1ns/10ps

module fetch_stage (
  input  logic                        clk,
  input  logic                        rst_n,

  // Controller
  input  logic                        pc_set_i,
  input  fetch_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  fetch_ctrl_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_data_pkg::irq_id_t     irq_id_i,
  input  logic                        kill_if_i,
  input  logic                        halt_if_i,
  input  logic                        id_ready_i,

  // Redirect sources
  input  fetch_data_pkg::mtvec_t      mtvec_i,
  input  fetch_data_pkg::addr_t       boot_addr_i,
  input  fetch_data_pkg::addr_t       jump_target_i,
  input  fetch_data_pkg::addr_t       branch_target_i,
  input  fetch_data_pkg::addr_t       mepc_i,
  input  fetch_data_pkg::addr_t       dpc_i,
  input  fetch_data_pkg::addr_t       dm_halt_addr_i,
  input  fetch_data_pkg::addr_t       dm_exception_addr_i,
  input  fetch_data_pkg::addr_t       nmi_addr_i,
  input  fetch_data_pkg::addr_t       fencei_pc_i,

  // Wishbone instruction bus
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output fetch_data_pkg::addr_t       wb_adr_o,
  output logic [3:0]                  wb_sel_o,
  input  fetch_data_pkg::instr_t      wb_dat_i,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,

  // Status and decode side
  output logic                        csr_mtvec_init_o,
  output logic                        if_valid_o,
  output fetch_data_pkg::addr_t       pc_if_o,
  output logic                        if_busy_o,
  output logic                        id_valid_o,
  output fetch_data_pkg::instr_t      id_instr_o,
  output fetch_data_pkg::addr_t       id_pc_o,
  output logic                        id_bus_err_o
);
  import fetch_data_pkg::*;

  addr_t  branch_addr;
  logic   pf_valid;
  instr_t pf_instr;
  logic   pf_err;
  logic   if_ready;

  fetch_bus_if bus_if ();

  fetch_pc_select pc_select_i (
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .mtvec_i             (mtvec_i),
    .boot_addr_i         (boot_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .nmi_addr_i          (nmi_addr_i),
    .fencei_pc_i         (fencei_pc_i),
    .pc_set_i            (pc_set_i),
    .branch_addr_o       (branch_addr),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  prefetch_buffer prefetch_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .ready_i       (if_ready),
    .valid_o       (pf_valid),
    .instr_o       (pf_instr),
    .pc_o          (pc_if_o),
    .err_o         (pf_err),
    .busy_o        (if_busy_o),
    .bus           (bus_if.requester)
  );

  wb_instr_master wb_master_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_err_i (wb_err_i),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_adr_o (wb_adr_o),
    .bus      (bus_if.responder)
  );

  // Read only, full words
  assign wb_we_o  = 1'b0;
  assign wb_sel_o = 4'hF;

  //////////////////////////////////////////////////
  // IF handshake and IF/ID register
  //////////////////////////////////////////////////

  // Nothing is presented while killed or halted
  assign if_valid_o = pf_valid && !kill_if_i && !halt_if_i;
  // Kill drops the head, halt keeps it in the buffer
  assign if_ready   = kill_if_i || (id_ready_i && !halt_if_i);

  // Valid follows IF whenever decode takes, holds otherwise
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      id_valid_o <= 1'b0;
    else if (id_ready_i)
      id_valid_o <= if_valid_o;
  end

  always_ff @(posedge clk)
  begin
    if (if_valid_o && id_ready_i)
    begin
      id_instr_o   <= pf_instr;
      id_pc_o      <= pc_if_o;
      id_bus_err_o <= pf_err;
    end
  end

endmodule

/* verification/fetch_stage_props.sv */
// Bus and output properties of the fetch stage, bound into fetch_stage
// Checked on rising clk edges, disabled during reset
// fail_cnt counts assertion failures for the testbench summary
`timescale 1ns/10ps

module fetch_stage_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  wb_cyc_o,
  input logic                  wb_stb_o,
  input fetch_data_pkg::addr_t wb_adr_o,
  input logic                  wb_ack_i,
  input logic                  wb_err_i,
  input logic                  pc_set_i,
  input logic                  kill_if_i,
  input logic                  halt_if_i,
  input logic                  pf_valid,
  input fetch_data_pkg::addr_t pc_if_o,
  input logic                  if_busy_o
);

  int unsigned fail_cnt = 0;

  // cyc and stb drop for one cycle after ack or err
  cyc_drop: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb_o && (wb_ack_i || wb_err_i)) |=> (!wb_cyc_o && !wb_stb_o))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("cyc or stb still high after the slave terminated");
  end

  // Address held until the slave terminates
  adr_held: assert property (@(posedge clk) disable iff (!rst_n)
    $past(wb_stb_o && !wb_ack_i && !wb_err_i) |-> (wb_adr_o == $past(wb_adr_o)))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("adr changed while stb waited for ack");
  end

  // One bus cycle at a time means busy follows cyc exactly
  busy_tracks_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    if_busy_o == wb_cyc_o)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("if_busy_o differs from the open bus cycle");
  end

  // Halt hides the buffer head from decode but keeps it in place
  head_held_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_if_i && !kill_if_i && !pc_set_i && pf_valid) |=> (pf_valid && $stable(pc_if_o)))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("buffer head lost or changed during halt");
  end

endmodule

bind fetch_stage fetch_stage_props props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .wb_cyc_o   (wb_cyc_o),
  .wb_stb_o   (wb_stb_o),
  .wb_adr_o   (wb_adr_o),
  .wb_ack_i   (wb_ack_i),
  .wb_err_i   (wb_err_i),
  .pc_set_i   (pc_set_i),
  .kill_if_i  (kill_if_i),
  .halt_if_i  (halt_if_i),
  .pf_valid   (pf_valid),
  .pc_if_o    (pc_if_o),
  .if_busy_o  (if_busy_o)
);

/* verification/fetch_stage_tb.sv */
// Testbench for the fetch stage
// Wishbone memory model returns address XOR a constant after 0 to 3 wait states
// Addresses with top nibble F answer with err instead of ack
// Every redirect is paired with kill_if_i, as the controller must do
`timescale 1ns/10ps

module fetch_stage_tb;
  import fetch_ctrl_pkg::*;
  import fetch_data_pkg::*;

  localparam int      NUM_ROWS  = 11;
  localparam int      TIMEOUT   = 400;
  localparam logic [31:0] RDATA_XOR = 32'hA5A5_0000;
  // Mid-stream events
  localparam logic [1:0] MID_NONE = 2'd0;
  localparam logic [1:0] MID_HALT = 2'd1;
  localparam logic [1:0] MID_JUMP = 2'd2;
  // Redirect sources, low bits set on purpose where alignment matters
  localparam addr_t  BOOT_ADDR  = 32'h0000_1003;
  localparam addr_t  JUMP_ADDR  = 32'h0000_2000;
  localparam addr_t  BRANCH_ADDR = 32'h0000_3006;
  localparam addr_t  MEPC_ADDR  = 32'h0000_4000;
  localparam addr_t  DPC_ADDR   = 32'h0000_5008;
  localparam addr_t  DBD_ADDR   = 32'h0000_8801;
  localparam addr_t  DBE_ADDR   = 32'hF000_0102;
  localparam addr_t  NMI_ADDR   = 32'h0000_9003;
  localparam addr_t  FENCEI_PC  = 32'h0000_6010;
  localparam mtvec_t MTVEC      = 24'h00_0070;
  // MRET redirect used mid-stream lands on mepc
  localparam addr_t  MID_TARGET = 32'h0000_4000;

  typedef struct packed {
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_mux;
    irq_id_t     irq;
    addr_t       target;
    logic [7:0]  count;
    logic        rand_rdy;
    logic [1:0]  mid;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        pc_set_i = 1'b0;
  pc_mux_e     pc_mux_i = PC_BOOT;
  exc_pc_mux_e exc_pc_mux_i = EXC_PC_EXCEPTION;
  irq_id_t     irq_id_i = '0;
  logic        kill_if_i = 1'b0;
  logic        halt_if_i = 1'b0;
  logic        id_ready_i = 1'b1;
  instr_t      wb_dat_i = '0;
  logic        wb_ack_i = 1'b0;
  logic        wb_err_i = 1'b0;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  addr_t       wb_adr_o;
  logic [3:0]  wb_sel_o;
  logic        csr_mtvec_init_o;
  logic        if_valid_o;
  addr_t       pc_if_o;
  logic        if_busy_o;
  logic        id_valid_o;
  instr_t      id_instr_o;
  addr_t       id_pc_o;
  logic        id_bus_err_o;

  row_t        rows [NUM_ROWS];
  integer      seed = 32'h9b3c4524;
  logic [31:0] rnd;
  logic [1:0]  draw;
  logic [1:0]  wait_cnt = '0;
  logic        pending = 1'b0;
  logic        rand_ready = 1'b0;
  // Scoreboard state
  addr_t       exp_pc = '0;
  // PC expected at the IF head
  addr_t       exp_if_pc = '0;
  // High for the cycle of a boot redirect
  logic        exp_init = 1'b0;
  int          seen = 0;
  int          init_pulses = 0;
  int          checks = 0;
  int          errors = 0;

  always #50 clk = ~clk;

  fetch_stage uut (
    .clk (clk), .rst_n (rst_n),
    .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i),
    .irq_id_i (irq_id_i), .kill_if_i (kill_if_i), .halt_if_i (halt_if_i),
    .id_ready_i (id_ready_i), .mtvec_i (MTVEC), .boot_addr_i (BOOT_ADDR),
    .jump_target_i (JUMP_ADDR), .branch_target_i (BRANCH_ADDR), .mepc_i (MEPC_ADDR),
    .dpc_i (DPC_ADDR), .dm_halt_addr_i (DBD_ADDR), .dm_exception_addr_i (DBE_ADDR),
    .nmi_addr_i (NMI_ADDR), .fencei_pc_i (FENCEI_PC),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o), .wb_adr_o (wb_adr_o),
    .wb_sel_o (wb_sel_o), .wb_dat_i (wb_dat_i), .wb_ack_i (wb_ack_i), .wb_err_i (wb_err_i),
    .csr_mtvec_init_o (csr_mtvec_init_o), .if_valid_o (if_valid_o), .pc_if_o (pc_if_o),
    .if_busy_o (if_busy_o), .id_valid_o (id_valid_o), .id_instr_o (id_instr_o),
    .id_pc_o (id_pc_o), .id_bus_err_o (id_bus_err_o)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////
  // Wishbone memory model and decode ready driver
  ////////////////////////////////////////////////////

  // One process draws all random numbers, so the sequence is fixed
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack_i   <= 1'b0;
      wb_err_i   <= 1'b0;
      pending    <= 1'b0;
      wait_cnt   <= '0;
      id_ready_i <= 1'b1;
    end
    else
    begin
      rnd = $random(seed);
      id_ready_i <= rand_ready ? rnd[31] : 1'b1;
      wb_ack_i <= 1'b0;
      wb_err_i <= 1'b0;
      // Open cycle not yet terminated
      if (wb_cyc_o && wb_stb_o && !wb_ack_i && !wb_err_i)
      begin
        if (!pending)
        begin
          rnd  = $random(seed);
          draw = rnd[1:0];
        end
        else
          draw = wait_cnt;
        if (draw == 2'd0)
        begin
          pending  <= 1'b0;
          wb_dat_i <= wb_adr_o ^ RDATA_XOR;
          if (wb_adr_o[31:28] == 4'hF)
            wb_err_i <= 1'b1;
          else
            wb_ack_i <= 1'b1;
        end
        else
        begin
          pending  <= 1'b1;
          wait_cnt <= draw - 2'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////
  // Decode-side monitor
  ////////////////////////////////////////////////////

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      check_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(exp_init));
      if (csr_mtvec_init_o)
        init_pulses++;
      if (wb_cyc_o)
      begin
        check_value("wb_we_o", 32'(wb_we_o), 32'd0);
        check_value("wb_sel_o", 32'(wb_sel_o), 32'hF);
      end
      // IF head moves to ID at the next edge when decode is ready
      if (if_valid_o)
      begin
        check_value("pc_if_o", pc_if_o, exp_if_pc);
        if (id_ready_i)
          exp_if_pc = exp_if_pc + 32'd4;
      end
      // Taken by decode at the next edge, except the redirect cycle
      if (id_valid_o && id_ready_i && !pc_set_i)
      begin
        check_value("id_pc_o", id_pc_o, exp_pc);
        check_value("id_bus_err_o", 32'(id_bus_err_o), 32'(exp_pc[31:28] == 4'hF));
        if (exp_pc[31:28] != 4'hF)
          check_value("id_instr_o", id_instr_o, exp_pc ^ RDATA_XOR);
        exp_pc = exp_pc + 32'd4;
        seen++;
      end
    end
  end

  // Redirect with kill, then the IF side must be empty
  task automatic apply_redirect(input pc_mux_e mux, input exc_pc_mux_e exc,
                                input irq_id_t irq, input addr_t target);
    rand_ready <= 1'b0;
    @(posedge clk);
    pc_set_i     <= 1'b1;
    kill_if_i    <= 1'b1;
    pc_mux_i     <= mux;
    exc_pc_mux_i <= exc;
    irq_id_i     <= irq;
    exp_init     <= (mux == PC_BOOT);
    exp_pc = target;
    exp_if_pc = target;
    @(posedge clk);
    pc_set_i  <= 1'b0;
    kill_if_i <= 1'b0;
    exp_init  <= 1'b0;
    @(negedge clk);
    checks++;
    assert (!id_valid_o && !if_valid_o)
    else
    begin
      errors++;
      $display("Old stream still visible right after the redirect at %0t", $time);
    end
  endtask

  task automatic wait_decoded(input int k);
    int start;
    int cycles;
    start  = seen;
    cycles = 0;
    while ((seen - start) < k && cycles < TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    checks++;
    assert ((seen - start) >= k)
    else
    begin
      errors++;
      $display("Timed out waiting for %0d instructions, next PC 0x%08h", k, exp_pc);
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus table and main sequence
  ////////////////////////////////////////////////////

  initial
  begin
    int half;
    // Targets worked out by hand from the selection rules
    rows[0]  = '{PC_BOOT, EXC_PC_EXCEPTION, 5'd0, 32'h0000_1000, 8'd6, 1'b0, MID_NONE};
    rows[1]  = '{PC_JUMP, EXC_PC_EXCEPTION, 5'd0, 32'h0000_2000, 8'd8, 1'b1, MID_NONE};
    rows[2]  = '{PC_BRANCH, EXC_PC_EXCEPTION, 5'd0, 32'h0000_3004, 8'd8, 1'b1, MID_HALT};
    rows[3]  = '{PC_MRET, EXC_PC_EXCEPTION, 5'd0, 32'h0000_4000, 8'd6, 1'b0, MID_NONE};
    rows[4]  = '{PC_DRET, EXC_PC_EXCEPTION, 5'd0, 32'h0000_5008, 8'd10, 1'b1, MID_JUMP};
    rows[5]  = '{PC_FENCEI, EXC_PC_EXCEPTION, 5'd0, 32'h0000_6014, 8'd6, 1'b0, MID_NONE};
    rows[6]  = '{PC_EXCEPTION, EXC_PC_EXCEPTION, 5'd0, 32'h0000_7000, 8'd6, 1'b1, MID_HALT};
    rows[7]  = '{PC_EXCEPTION, EXC_PC_IRQ, 5'd19, 32'h0000_704C, 8'd6, 1'b0, MID_NONE};
    rows[8]  = '{PC_EXCEPTION, EXC_PC_DBD, 5'd0, 32'h0000_8800, 8'd6, 1'b1, MID_NONE};
    rows[9]  = '{PC_EXCEPTION, EXC_PC_DBE, 5'd0, 32'hF000_0100, 8'd6, 1'b0, MID_NONE};
    rows[10] = '{PC_EXCEPTION, EXC_PC_NMI, 5'd0, 32'h0000_9000, 8'd8, 1'b1, MID_HALT};

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      apply_redirect(rows[r].pc_mux, rows[r].exc_mux, rows[r].irq, rows[r].target);
      rand_ready <= rows[r].rand_rdy;
      half = int'(rows[r].count) / 2;
      wait_decoded(half);
      if (rows[r].mid == MID_HALT)
      begin
        // Buffer fills and stalls, nothing may be lost
        @(posedge clk);
        halt_if_i <= 1'b1;
        repeat (12) @(posedge clk);
        halt_if_i <= 1'b0;
      end
      else if (rows[r].mid == MID_JUMP)
      begin
        // Redirect with responses still in flight
        apply_redirect(PC_MRET, EXC_PC_EXCEPTION, '0, MID_TARGET);
        rand_ready <= rows[r].rand_rdy;
      end
      wait_decoded(int'(rows[r].count) - half);
    end

    checks++;
    assert (init_pulses == 1)
    else
    begin
      errors++;
      $display("mtvec init pulsed %0d times instead of once", init_pulses);
    end
    errors += int'(uut.props_i.fail_cnt);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.props_i.fail_cnt);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/fetch_data_pkg.sv
design/fetch_ctrl_pkg.sv
design/fetch_bus_if.sv
design/fetch_pc_select.sv
design/prefetch_buffer.sv
design/wb_instr_master.sv
design/fetch_stage.sv
verification/fetch_stage_props.sv
verification/fetch_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fetch_stage_tb \
  -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
sim_out=$(./obj_dir/Vfetch_stage_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -Fqx "=== PASS ==="; then
  exit 0
fi
exit 1
